/* src/databus_pkg.sv */
package databus_pkg;

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = 4;
  localparam int LEN_W     = 8;   // Beats minus one
  localparam int N_UNITS   = 2;
  localparam int UNIT_W    = 1;
  localparam int MAX_BURST = 16;  // Also the 64-byte line in words

  // Byte offset bits in a word and word index bits in a line
  localparam int BYTE_W  = $clog2(STRB_W);
  localparam int BURST_W = $clog2(MAX_BURST);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [UNIT_W-1:0] unit_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;   // Zero for a read
    len_t  len;
  } databus_req_t;

  typedef struct packed {
    logic  ready;
    logic  last;
    word_t rdata;
  } databus_resp_t;

  // Shared by AW and AR
  typedef struct packed {
    addr_t addr;
    len_t  len;
  } axi_ax_t;

  typedef struct packed {
    word_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    word_t data;
    logic  last;
  } axi_r_t;

  // Granted request as seen by an engine
  typedef struct packed {
    addr_t addr;
    len_t  len;
    word_t wdata;
    strb_t wstrb;
  } xfer_t;

  typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA} eng_state_t;

endpackage

/* src/databus_merge.sv */
`timescale 1ns/1ns

module databus_merge (
  input  logic                       clk,
  input  logic                       rst,
  input  databus_pkg::databus_req_t  unit_req [databus_pkg::N_UNITS],
  output databus_pkg::databus_resp_t unit_resp [databus_pkg::N_UNITS],
  output logic                       wr_busy,
  output logic                       rd_busy,
  output databus_pkg::xfer_t         wr_xfer,
  output databus_pkg::xfer_t         rd_xfer,
  output logic                       wr_beat_valid,
  output logic                       rd_beat_valid,
  input  logic                       wr_beat_ready,
  input  logic                       wr_beat_last,
  input  logic                       rd_beat_ready,
  input  logic                       rd_beat_last,
  input  databus_pkg::word_t         rd_data
);
  import databus_pkg::*;

  unit_t        wr_unit;
  unit_t        rd_unit;
  logic         wr_req;
  logic         rd_req;
  unit_t        wr_pick;
  unit_t        rd_pick;
  databus_req_t wr_src;
  databus_req_t rd_src;

  // Later units overwrite earlier ones, so the highest index wins
  always_comb begin
    wr_req  = 1'b0;
    rd_req  = 1'b0;
    wr_pick = '0;
    rd_pick = '0;
    for (int i = 0; i < N_UNITS; i++) begin
      if (unit_req[i].valid) begin
        if (|unit_req[i].wstrb) begin
          wr_req  = 1'b1;
          wr_pick = unit_t'(i);
        end else begin
          rd_req  = 1'b1;
          rd_pick = unit_t'(i);
        end
      end
    end
  end

  // Each channel is held by one unit until its last beat goes through
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_busy <= 1'b0;
      wr_unit <= '0;
      rd_busy <= 1'b0;
      rd_unit <= '0;
    end else begin
      if (!wr_busy && wr_req) begin
        wr_busy <= 1'b1;
        wr_unit <= wr_pick;
      end else if (wr_beat_valid && wr_beat_ready && wr_beat_last) begin
        wr_busy <= 1'b0;
      end

      if (!rd_busy && rd_req) begin
        rd_busy <= 1'b1;
        rd_unit <= rd_pick;
      end else if (rd_beat_valid && rd_beat_ready && rd_beat_last) begin
        rd_busy <= 1'b0;
      end
    end
  end

  assign wr_src = unit_req[wr_unit];
  assign rd_src = unit_req[rd_unit];

  assign wr_xfer = '{
    addr:  wr_src.addr,
    len:   wr_src.len,
    wdata: wr_src.wdata,
    wstrb: wr_src.wstrb
  };
  assign rd_xfer = '{addr: rd_src.addr, len: rd_src.len, wdata: '0, wstrb: '0};

  assign wr_beat_valid = wr_busy && wr_src.valid;
  assign rd_beat_valid = rd_busy && rd_src.valid;

  // Ready and last reach only the granted unit
  for (genvar g = 0; g < N_UNITS; g++) begin : g_resp
    logic wr_hit;
    logic rd_hit;

    assign wr_hit = wr_busy && (wr_unit == unit_t'(g)) && wr_beat_ready;
    assign rd_hit = rd_busy && (rd_unit == unit_t'(g)) && rd_beat_ready;

    assign unit_resp[g] = '{
      ready: wr_hit || rd_hit,
      last:  (wr_hit && wr_beat_last) || (rd_hit && rd_beat_last),
      rdata: rd_hit ? rd_data : '0
    };
  end

endmodule

/* src/burst_splitter.sv */
`timescale 1ns/1ns

module burst_splitter (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  databus_pkg::xfer_t xfer,
  input  logic               burst_done,
  output databus_pkg::addr_t burst_addr,
  output databus_pkg::len_t  burst_len,
  output logic               final_burst
);
  import databus_pkg::*;

  addr_t            cur_addr;
  logic [LEN_W:0]   beats_left;   // Up to 256 words
  logic [BURST_W:0] bound_beats;
  logic [LEN_W:0]   burst_beats;

  // Words left before the next line boundary
  assign bound_beats = (BURST_W+1)'(MAX_BURST)
                     - {1'b0, cur_addr[BYTE_W+BURST_W-1:BYTE_W]};

  always_comb begin
    if (beats_left > (LEN_W+1)'(bound_beats)) begin
      burst_beats = (LEN_W+1)'(bound_beats);
    end else begin
      burst_beats = beats_left;
    end
  end

  assign burst_addr  = cur_addr;
  assign burst_len   = LEN_W'(burst_beats - 1'b1);
  assign final_burst = (burst_beats == beats_left);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cur_addr   <= '0;
      beats_left <= '0;
    end else if (start) begin
      cur_addr   <= xfer.addr;
      beats_left <= {1'b0, xfer.len} + 1'b1;
    end else if (burst_done) begin
      // Step past the words just sent
      cur_addr   <= cur_addr + (ADDR_W'(burst_beats) << BYTE_W);
      beats_left <= beats_left - burst_beats;
    end
  end

endmodule

/* src/axi_write_engine.sv */
`timescale 1ns/1ns

// AXI side runs 4-byte INCR bursts with ID 0, cache 2, prot 2
module axi_write_engine (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 busy,
  input  databus_pkg::xfer_t   xfer,
  input  logic                 beat_valid,
  output logic                 beat_ready,
  output logic                 beat_last,
  output logic                 split_start,
  output logic                 burst_done,
  input  databus_pkg::addr_t   burst_addr,
  input  databus_pkg::len_t    burst_len,
  input  logic                 final_burst,
  output databus_pkg::axi_ax_t aw,
  output logic                 awvalid,
  input  logic                 awready,
  output databus_pkg::axi_w_t  w,
  output logic                 wvalid,
  input  logic                 wready,
  output logic                 bready
);
  import databus_pkg::*;

  eng_state_t state;
  len_t       beat_cnt;   // Beat index in the current burst
  logic       in_data;
  logic       w_fire;

  assign in_data     = (state == ST_DATA);
  assign split_start = (state == ST_IDLE) && busy;

  assign aw = '{addr: burst_addr, len: burst_len};
  assign w  = '{data: xfer.wdata, strb: xfer.wstrb, last: beat_cnt == burst_len};

  assign wvalid     = in_data && beat_valid;
  assign beat_ready = in_data && wready;
  assign w_fire     = wvalid && wready;
  assign burst_done = w_fire && w.last;
  assign beat_last  = in_data && w.last && final_burst;

  assign bready = 1'b1;   // B channel ignored

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= ST_IDLE;
      awvalid  <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (busy) begin
            state   <= ST_ADDR;
            awvalid <= 1'b1;
          end
        end
        ST_ADDR: begin
          if (awready) begin
            state   <= ST_DATA;
            awvalid <= 1'b0;
          end
        end
        ST_DATA: begin
          if (w_fire) begin
            if (w.last) begin
              beat_cnt <= '0;
              if (final_burst) begin
                state <= ST_IDLE;
              end else begin
                // Next burst address goes out right away
                state   <= ST_ADDR;
                awvalid <= 1'b1;
              end
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* src/axi_read_engine.sv */
`timescale 1ns/1ns

// Same burst shape as the write side; rlast from the slave ends each burst
module axi_read_engine (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 busy,
  input  logic                 beat_valid,
  output logic                 beat_ready,
  output logic                 beat_last,
  output databus_pkg::word_t   beat_data,
  output logic                 split_start,
  output logic                 burst_done,
  input  databus_pkg::addr_t   burst_addr,
  input  databus_pkg::len_t    burst_len,
  input  logic                 final_burst,
  output databus_pkg::axi_ax_t ar,
  output logic                 arvalid,
  input  logic                 arready,
  input  databus_pkg::axi_r_t  r,
  input  logic                 rvalid,
  output logic                 rready
);
  import databus_pkg::*;

  eng_state_t state;
  logic       in_data;
  logic       r_fire;

  assign in_data     = (state == ST_DATA);
  assign split_start = (state == ST_IDLE) && busy;

  assign ar = '{addr: burst_addr, len: burst_len};

  // Unit valid paces the R channel
  assign rready     = in_data && beat_valid;
  assign beat_ready = in_data && rvalid;
  assign beat_data  = r.data;
  assign r_fire     = rvalid && rready;
  assign burst_done = r_fire && r.last;
  assign beat_last  = in_data && r.last && final_burst;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= ST_IDLE;
      arvalid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (busy) begin
            state   <= ST_ADDR;
            arvalid <= 1'b1;
          end
        end
        ST_ADDR: begin
          if (arready) begin
            state   <= ST_DATA;
            arvalid <= 1'b0;
          end
        end
        ST_DATA: begin
          if (r_fire && r.last) begin
            if (final_burst) begin
              state <= ST_IDLE;
            end else begin
              state   <= ST_ADDR;
              arvalid <= 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* src/databus_axi_top.sv */
`timescale 1ns/1ns

module databus_axi_top (
  input  logic                       clk,
  input  logic                       rst,
  input  databus_pkg::databus_req_t  unit_req [databus_pkg::N_UNITS],
  output databus_pkg::databus_resp_t unit_resp [databus_pkg::N_UNITS],
  output databus_pkg::axi_ax_t       aw,
  output logic                       awvalid,
  input  logic                       awready,
  output databus_pkg::axi_w_t        w,
  output logic                       wvalid,
  input  logic                       wready,
  input  logic                       bvalid,    // Responses not tracked
  output logic                       bready,
  output databus_pkg::axi_ax_t       ar,
  output logic                       arvalid,
  input  logic                       arready,
  input  databus_pkg::axi_r_t        r,
  input  logic                       rvalid,
  output logic                       rready
);
  import databus_pkg::*;

  logic  wr_busy, wr_beat_valid, wr_beat_ready, wr_beat_last;
  logic  rd_busy, rd_beat_valid, rd_beat_ready, rd_beat_last;
  xfer_t wr_xfer, rd_xfer;
  word_t rd_data;

  logic  wr_split_start, wr_burst_done, wr_final_burst;
  logic  rd_split_start, rd_burst_done, rd_final_burst;
  addr_t wr_burst_addr, rd_burst_addr;
  len_t  wr_burst_len, rd_burst_len;

  databus_merge merge_i (
    .clk(clk), .rst(rst),
    .unit_req(unit_req), .unit_resp(unit_resp),
    .wr_busy(wr_busy), .rd_busy(rd_busy),
    .wr_xfer(wr_xfer), .rd_xfer(rd_xfer),
    .wr_beat_valid(wr_beat_valid), .rd_beat_valid(rd_beat_valid),
    .wr_beat_ready(wr_beat_ready), .wr_beat_last(wr_beat_last),
    .rd_beat_ready(rd_beat_ready), .rd_beat_last(rd_beat_last),
    .rd_data(rd_data)
  );

  burst_splitter wr_split_i (
    .clk(clk), .rst(rst), .start(wr_split_start), .xfer(wr_xfer),
    .burst_done(wr_burst_done), .burst_addr(wr_burst_addr),
    .burst_len(wr_burst_len), .final_burst(wr_final_burst)
  );

  burst_splitter rd_split_i (
    .clk(clk), .rst(rst), .start(rd_split_start), .xfer(rd_xfer),
    .burst_done(rd_burst_done), .burst_addr(rd_burst_addr),
    .burst_len(rd_burst_len), .final_burst(rd_final_burst)
  );

  axi_write_engine wr_eng_i (
    .clk(clk), .rst(rst), .busy(wr_busy), .xfer(wr_xfer),
    .beat_valid(wr_beat_valid), .beat_ready(wr_beat_ready), .beat_last(wr_beat_last),
    .split_start(wr_split_start), .burst_done(wr_burst_done),
    .burst_addr(wr_burst_addr), .burst_len(wr_burst_len), .final_burst(wr_final_burst),
    .aw(aw), .awvalid(awvalid), .awready(awready),
    .w(w), .wvalid(wvalid), .wready(wready), .bready(bready)
  );

  axi_read_engine rd_eng_i (
    .clk(clk), .rst(rst), .busy(rd_busy),
    .beat_valid(rd_beat_valid), .beat_ready(rd_beat_ready), .beat_last(rd_beat_last),
    .beat_data(rd_data),
    .split_start(rd_split_start), .burst_done(rd_burst_done),
    .burst_addr(rd_burst_addr), .burst_len(rd_burst_len), .final_burst(rd_final_burst),
    .ar(ar), .arvalid(arvalid), .arready(arready),
    .r(r), .rvalid(rvalid), .rready(rready)
  );

endmodule

/* sim/axi_mem_model.sv */
`timescale 1ns/1ns

module axi_mem_model (
  input  logic                 clk,
  input  logic                 rst,
  input  databus_pkg::axi_ax_t aw,
  input  logic                 awvalid,
  output logic                 awready,
  input  databus_pkg::axi_w_t  w,
  input  logic                 wvalid,
  output logic                 wready,
  output logic                 bvalid,
  input  logic                 bready,
  input  databus_pkg::axi_ax_t ar,
  input  logic                 arvalid,
  output logic                 arready,
  output databus_pkg::axi_r_t  r,
  output logic                 rvalid,
  input  logic                 rready,
  output logic                 proto_err
);
  import databus_pkg::*;

  word_t       mem [addr_t];   // Keyed by word address
  logic [31:0] rnd;
  logic        w_act, r_act;
  addr_t       wa, ra;
  len_t        wlen, wcnt, rlen, rcnt;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Untouched words read back a pattern built from the full address
  function automatic word_t mem_word(input addr_t a);
    if (mem.exists(a >> BYTE_W)) begin
      return mem[a >> BYTE_W];
    end
    return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
  endfunction

  function automatic logic burst_fits(input axi_ax_t ax);
    return (int'(ax.len) < MAX_BURST)
        && (int'(ax.addr[BYTE_W+BURST_W-1:BYTE_W]) + int'(ax.len) < MAX_BURST);
  endfunction

  always @(posedge clk or posedge rst) begin : slave
    logic [31:0] nr;
    logic        w_nxt, r_nxt;
    addr_t       ra_nxt;
    len_t        rcnt_nxt, rlen_nxt;
    word_t       cur;
    if (rst) begin
      awready   <= 1'b0;
      wready    <= 1'b0;
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      bvalid    <= 1'b0;
      r         <= '0;
      w_act     <= 1'b0;
      r_act     <= 1'b0;
      wa        <= '0;
      ra        <= '0;
      wlen      <= '0;
      wcnt      <= '0;
      rlen      <= '0;
      rcnt      <= '0;
      proto_err <= 1'b0;
      rnd       <= 32'he834_2e58;
    end else begin
      nr       = xorshift(rnd);
      rnd      <= nr;
      w_nxt    = w_act;
      r_nxt    = r_act;
      ra_nxt   = ra;
      rcnt_nxt = rcnt;
      rlen_nxt = rlen;
      if (bready) bvalid <= 1'b0;   // Response held until taken
      if (awvalid && awready) begin
        if (!burst_fits(aw)) begin
          $display("write burst at %h with len %h is over 16 beats or crosses 64 bytes",
                   aw.addr, aw.len);
          proto_err <= 1'b1;
        end
        wa    <= aw.addr;
        wlen  <= aw.len;
        wcnt  <= '0;
        w_nxt = 1'b1;
      end
      if (wvalid && wready) begin
        cur = mem_word(wa);
        for (int b = 0; b < STRB_W; b++) begin
          if (w.strb[b]) cur[b*8 +: 8] = w.data[b*8 +: 8];
        end
        mem[wa >> BYTE_W] = cur;
        if (w.last != (wcnt == wlen)) begin
          $display("wlast on the wrong beat of the burst at %h", wa);
          proto_err <= 1'b1;
        end
        wa   <= wa + STRB_W;
        wcnt <= wcnt + 1'b1;
        if (w.last) begin
          w_nxt = 1'b0;
          bvalid <= 1'b1;
        end
      end
      if (arvalid && arready) begin
        if (!burst_fits(ar)) begin
          $display("read burst at %h with len %h is over 16 beats or crosses 64 bytes",
                   ar.addr, ar.len);
          proto_err <= 1'b1;
        end
        ra_nxt   = ar.addr;
        rlen_nxt = ar.len;
        rcnt_nxt = '0;
        r_nxt    = 1'b1;
      end
      if (rvalid && rready) begin
        ra_nxt   = ra + STRB_W;
        rcnt_nxt = rcnt + 1'b1;
        if (r.last) r_nxt = 1'b0;
      end
      w_act   <= w_nxt;
      r_act   <= r_nxt;
      ra      <= ra_nxt;
      rcnt    <= rcnt_nxt;
      rlen    <= rlen_nxt;
      awready <= !w_nxt && (nr[1:0] != 2'b00);   // Random stalls
      wready  <= w_nxt && (nr[3:2] != 2'b00);
      arready <= !r_nxt && (nr[5:4] != 2'b00);
      if (!(rvalid && !rready)) begin   // R beat holds until taken
        rvalid <= r_nxt && (nr[7:6] != 2'b00);
        r      <= '{data: mem_word(ra_nxt), last: rcnt_nxt == rlen_nxt};
      end
    end
  end

endmodule

/* sim/tb_databus_axi.sv */
`timescale 1ns/1ns

module tb_databus_axi;
  import databus_pkg::*;

  localparam int VEC_ROWS = 40;
  localparam int VEC_COLS = 6;

  logic          clk;
  logic          rst;
  databus_req_t  unit_req [N_UNITS];
  databus_resp_t unit_resp [N_UNITS];
  axi_ax_t       aw, ar;
  axi_w_t        w;
  axi_r_t        r;
  logic          awvalid, awready, wvalid, wready, bvalid, bready;
  logic          arvalid, arready, rvalid, rready, mem_err;

  logic [31:0] vec [VEC_ROWS*VEC_COLS];
  word_t       ref_mem [addr_t];   // Expected memory, word keyed
  axi_ax_t     exp_aw_q [$];
  axi_ax_t     exp_ar_q [$];
  int          bar_cnt [N_UNITS];
  logic        wr_owned, rd_owned;
  unit_t       wr_owner, rd_owner;
  logic        started;
  int          n_vec, words, cycles, limit;

  databus_axi_top dut_i (
    .clk(clk), .rst(rst), .unit_req(unit_req), .unit_resp(unit_resp),
    .aw(aw), .awvalid(awvalid), .awready(awready),
    .w(w), .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready),
    .ar(ar), .arvalid(arvalid), .arready(arready),
    .r(r), .rvalid(rvalid), .rready(rready)
  );

  axi_mem_model mem_i (
    .clk(clk), .rst(rst), .aw(aw), .awvalid(awvalid), .awready(awready),
    .w(w), .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready),
    .ar(ar), .arvalid(arvalid), .arready(arready),
    .r(r), .rvalid(rvalid), .rready(rready), .proto_err(mem_err)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped on first error");
  endtask

  task automatic check_resp(input string name, input databus_resp_t got,
                            input databus_resp_t exp, input logic with_data);
    if (got.last !== exp.last) begin
      fail_run($sformatf("mismatch %s.last got %h exp %h", name, got.last, exp.last));
    end
    if (with_data && got.rdata !== exp.rdata) begin
      fail_run($sformatf("mismatch %s.rdata got %h exp %h", name, got.rdata, exp.rdata));
    end
  endtask

  task automatic check_ax(input string name, input axi_ax_t got, input axi_ax_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s addr/len got %h/%h exp %h/%h",
                         name, got.addr, got.len, exp.addr, exp.len));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("mismatch %s got %h exp %h", name, got, exp));
  endtask

  // Boundary rule: each burst stops at 16 beats or the next 64-byte line
  function automatic void plan_bursts(input logic is_wr, input addr_t a, input len_t len);
    int left;
    int room;
    int n;
    left = int'(len) + 1;
    while (left > 0) begin
      room = MAX_BURST - int'(a[BYTE_W+BURST_W-1:BYTE_W]);
      n    = (left < room) ? left : room;
      if (is_wr) exp_aw_q.push_back(axi_ax_t'{addr: a, len: len_t'(n - 1)});
      else exp_ar_q.push_back(axi_ax_t'{addr: a, len: len_t'(n - 1)});
      a    = a + addr_t'(n * STRB_W);
      left = left - n;
    end
  endfunction

  function automatic logic barrier_reached(input int k);
    foreach (bar_cnt[u]) begin
      if (bar_cnt[u] < k) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic do_transfer(input int u, input logic is_wr, input addr_t addr,
                             input len_t len, input strb_t strb, input word_t seed);
    int            n;
    word_t         data;
    word_t         cur;
    addr_t         key;
    databus_resp_t exp;
    n    = 0;
    data = is_wr ? xorshift(seed) : '0;
    @(posedge clk);
    started = 1'b1;
    unit_req[u] <= '{valid: 1'b1, addr: addr, wdata: data,
                     wstrb: is_wr ? strb : '0, len: len};
    while (n <= int'(len)) begin
      @(negedge clk);
      if (unit_resp[u].ready) begin
        key = (addr >> BYTE_W) + addr_t'(n);
        exp = '{ready: 1'b1, last: n == int'(len), rdata: '0};
        if (is_wr) begin
          cur = ref_mem.exists(key) ? ref_mem[key] : '0;
          for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) cur[b*8 +: 8] = data[b*8 +: 8];
          end
          ref_mem[key] = cur;
        end else if (!ref_mem.exists(key)) begin
          fail_run($sformatf("unit %0d read word %h that was never written", u, key));
        end else begin
          exp.rdata = ref_mem[key];
        end
        check_resp($sformatf("unit_resp[%0d]", u), unit_resp[u], exp, !is_wr);
        n++;
        @(posedge clk);
        if (n > int'(len)) begin
          unit_req[u].valid <= 1'b0;
        end else if (is_wr) begin
          data = xorshift(data);
          unit_req[u].wdata <= data;
        end
      end
    end
  endtask

  // Op 0 read, 1 write, 2 wait for all units
  task automatic run_unit(input int u);
    logic [31:0] op;
    int          k;
    for (int i = 0; i < n_vec; i++) begin
      op = vec[i*VEC_COLS];
      if (op == 2) begin
        bar_cnt[u]++;
        k = bar_cnt[u];
        do @(negedge clk); while (!barrier_reached(k));
      end else if (vec[i*VEC_COLS+1] == u) begin
        do_transfer(u, op == 1, vec[i*VEC_COLS+2], len_t'(vec[i*VEC_COLS+3]),
                    strb_t'(vec[i*VEC_COLS+4]), vec[i*VEC_COLS+5]);
      end
    end
  endtask

  // Channel owner model: highest requesting unit, held until its last beat
  always @(negedge clk) begin : monitor
    logic  found;
    unit_t pick;
    if (!rst) begin
      if (mem_err) fail_run("memory model saw a bad burst");
      if (!started) begin
        foreach (unit_resp[u]) begin
          check_bit($sformatf("unit_resp[%0d].ready", u), unit_resp[u].ready, 1'b0);
          check_bit($sformatf("unit_resp[%0d].last", u), unit_resp[u].last, 1'b0);
        end
        check_bit("awvalid", awvalid, 1'b0);
        check_bit("arvalid", arvalid, 1'b0);
        check_bit("wvalid", wvalid, 1'b0);
        check_bit("rready", rready, 1'b0);
      end
      check_bit("bready", bready, 1'b1);
      if (wr_owned) begin
        if (unit_req[wr_owner].valid && unit_resp[wr_owner].ready
            && unit_resp[wr_owner].last) begin
          if (exp_aw_q.size() != 0) fail_run("write finished with bursts not issued");
          wr_owned = 1'b0;
        end
      end else begin
        found = 1'b0;
        foreach (unit_req[u]) begin
          if (unit_req[u].valid && |unit_req[u].wstrb) begin
            found = 1'b1;
            pick  = unit_t'(u);
          end
        end
        if (found) begin
          wr_owned = 1'b1;
          wr_owner = pick;
          plan_bursts(1'b1, unit_req[pick].addr, unit_req[pick].len);
        end
      end
      if (rd_owned) begin
        if (unit_req[rd_owner].valid && unit_resp[rd_owner].ready
            && unit_resp[rd_owner].last) begin
          if (exp_ar_q.size() != 0) fail_run("read finished with bursts not issued");
          rd_owned = 1'b0;
        end
      end else begin
        found = 1'b0;
        foreach (unit_req[u]) begin
          if (unit_req[u].valid && !(|unit_req[u].wstrb)) begin
            found = 1'b1;
            pick  = unit_t'(u);
          end
        end
        if (found) begin
          rd_owned = 1'b1;
          rd_owner = pick;
          plan_bursts(1'b0, unit_req[pick].addr, unit_req[pick].len);
        end
      end
      if (awvalid && awready) begin
        if (exp_aw_q.size() == 0) fail_run("write burst with no transfer pending");
        check_ax("aw", aw, exp_aw_q.pop_front());
      end
      if (arvalid && arready) begin
        if (exp_ar_q.size() == 0) fail_run("read burst with no transfer pending");
        check_ax("ar", ar, exp_ar_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) fail_run($sformatf("timeout after %0d cycles", cycles));
  end

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    started  = 1'b0;
    wr_owned = 1'b0;
    rd_owned = 1'b0;
    cycles   = 0;
    limit    = 0;
    words    = 0;
    n_vec    = 0;
    foreach (unit_req[u]) unit_req[u] = '0;
    foreach (bar_cnt[u]) bar_cnt[u] = 0;
    $readmemh("sim/databus_vectors.txt", vec);
    while (n_vec < VEC_ROWS && vec[n_vec*VEC_COLS] != 32'hf) begin
      if (vec[n_vec*VEC_COLS] < 2) words += int'(vec[n_vec*VEC_COLS+3]) + 1;
      n_vec++;
    end
    limit = 20 * words + 200;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);   // Idle window before any request
    for (int i = 0; i < N_UNITS; i++) begin
      fork
        automatic int u = i;
        run_unit(u);
      join_none
    end
    wait fork;
    repeat (4) @(negedge clk);
    if (!wr_owned && !rd_owned && exp_aw_q.size() == 0 && exp_ar_q.size() == 0
        && !awvalid && !arvalid && !wvalid && !rready) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("transfers or bus requests still open at the end of the run");
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped with open transfers");
    end
  end

endmodule

/* sim/databus_vectors.txt */
// op unit addr len strb seed  (op 0 read, 1 write, 2 sync all units, f end)
// len is beats minus one, all fields hex
1 0 00000100 07 f 0000a11c
0 0 00000100 07 0 00000000
2 0 00000000 00 0 00000000
1 1 00000218 27 f 5eed0002
0 1 00000218 27 0 00000000
2 0 00000000 00 0 00000000
1 0 00000400 0f f 5eed0003
0 1 00000100 07 0 00000000
2 0 00000000 00 0 00000000
1 0 00000600 03 f 5eed0004
1 1 00000640 05 f 5eed0005
2 0 00000000 00 0 00000000
0 0 00000400 0f 0 00000000
0 1 00000600 03 0 00000000
0 0 00000640 05 0 00000000
2 0 00000000 00 0 00000000
1 0 00000218 03 5 5eed0006
1 0 00000108 01 8 5eed0007
1 1 0000073c 20 f 5eed0008
2 0 00000000 00 0 00000000
0 1 00000218 07 0 00000000
0 0 00000100 07 0 00000000
0 1 0000073c 20 0 00000000
f 0 00000000 00 0 00000000

/* tb.f */
src/databus_pkg.sv
src/databus_merge.sv
src/burst_splitter.sv
src/axi_write_engine.sv
src/axi_read_engine.sv
src/databus_axi_top.sv
sim/axi_mem_model.sv
sim/tb_databus_axi.sv
